// ==== sources.f ====
+incdir+verification
src/order_pkg.sv
src/book_pkg.sv
src/side_book.sv
src/best_price_tracker.sv
src/book_controller.sv
src/order_book_top.sv
verification/order_book_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the order book testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -sv -f sources.f --top-module order_book_tb \
        -o order_book_sim; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/order_book_sim)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with no errors" <<< "$output"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// ==== verification/order_book_tests.svh ====
// directed tests and a scoreboard of every stock and side
// side index 1 is bid, 0 is ask, as in order_pkg::side_e
int          m_count [NUM_STOCKS][2];
logic [31:0] m_price [NUM_STOCKS][2][BOOK_DEPTH];
logic [31:0] m_id [NUM_STOCKS][2][BOOK_DEPTH];
logic [15:0] m_qty [NUM_STOCKS][2][BOOK_DEPTH];
logic [31:0] last_bid;
logic [31:0] last_ask;
logic [31:0] next_id = 32'd100;

function automatic int find_slot(input int s, input int side, input logic [31:0] id);
    for (int i = 0; i < m_count[s][side]; i++) begin
        if (m_id[s][side][i] == id) begin
            return i;
        end
    end
    return -1;
endfunction

// highest bid or lowest ask, -1 when empty
function automatic int best_slot(input int s, input int side);
    int b;
    b = -1;
    for (int i = 0; i < m_count[s][side]; i++) begin
        if (b < 0 || (side == 1 ? m_price[s][side][i] > m_price[s][side][b]
                                : m_price[s][side][i] < m_price[s][side][b])) begin
            b = i;
        end
    end
    return b;
endfunction

function automatic logic [31:0] best_price(input int s, input int side);
    int b;
    b = best_slot(s, side);
    return (b < 0) ? 32'd0 : m_price[s][side][b];
endfunction

task automatic remove_slot(input int s, input int side, input int k);
    for (int i = k; i < m_count[s][side] - 1; i++) begin
        m_price[s][side][i] = m_price[s][side][i + 1];
        m_id[s][side][i]    = m_id[s][side][i + 1];
        m_qty[s][side][i]   = m_qty[s][side][i + 1];
    end
    m_count[s][side]--;
endtask

task automatic model_apply(input order_pkg::op_e op, input int side, input int s,
                           input logic [15:0] qty, input logic [31:0] price,
                           input logic [31:0] id);
    int k;
    k = find_slot(s, side, id);
    if (op == order_pkg::OP_ADD) begin
        // a full side ignores the add
        if (m_count[s][side] < BOOK_DEPTH) begin
            m_price[s][side][m_count[s][side]] = price;
            m_id[s][side][m_count[s][side]]    = id;
            m_qty[s][side][m_count[s][side]]   = qty;
            m_count[s][side]++;
        end
    end else if (k >= 0) begin
        if (op == order_pkg::OP_EXECUTE && qty < m_qty[s][side][k]) begin
            m_qty[s][side][k] = m_qty[s][side][k] - qty;
        end else begin
            remove_slot(s, side, k);
        end
    end
endtask

task automatic issue_cmd(input order_pkg::op_e op, input int side, input int s,
                         input logic [15:0] qty, input logic [31:0] price,
                         input logic [31:0] id);
    order_pkg::order_msg_t msg;
    msg.side     = order_pkg::side_e'(side[0]);
    msg.op       = op;
    msg.stock    = s[1:0];
    msg.quantity = qty;
    msg.price    = price;
    msg.order_id = id;
    @(posedge i_clk);
    i_order       <= msg;
    i_query_stock <= s[1:0];
    i_data_valid  <= 1'b1;
    @(posedge i_clk);
    i_data_valid <= 1'b0;
endtask

task automatic wait_done(input string name);
    int cycles;
    cycles = 0;
    @(negedge i_clk);
    while (!o_data_valid) begin
        check_value({name, " busy"}, 32'd1, 32'(o_book_is_busy));
        if (cycles == WAIT_LIMIT) begin
            $display("timeout: o_data_valid never rose during %s", name);
            report_failure();
        end else begin
            @(negedge i_clk);
            cycles++;
        end
    end
endtask

task automatic release_book();
    @(posedge i_clk);
    i_trading_logic_ready <= 1'b1;
    @(posedge i_clk);
    i_trading_logic_ready <= 1'b0;
endtask

task automatic send_cmd(input string name, input order_pkg::op_e op, input int side,
                        input int s, input logic [15:0] qty, input logic [31:0] price,
                        input logic [31:0] id);
    issue_cmd(op, side, s, qty, price, id);
    model_apply(op, side, s, qty, price, id);
    wait_done(name);
    @(negedge i_clk);
    last_bid = o_quote.bid_price;
    last_ask = o_quote.ask_price;
    check_value({name, " bid"}, best_price(s, 1), last_bid);
    check_value({name, " ask"}, best_price(s, 0), last_ask);
    release_book();
endtask

task automatic add_random(input string name, input int s, input int side);
    logic [31:0] price;
    logic [15:0] qty;
    price = random_bits(12) + 32'd1;
    qty   = 16'(random_bits(6)) + 16'd8;
    send_cmd(name, order_pkg::OP_ADD, side, s, qty, price, next_id);
    next_id++;
endtask

task automatic read_quote(input int s, output logic [31:0] bid, output logic [31:0] ask);
    @(posedge i_clk);
    i_query_stock <= s[1:0];
    @(posedge i_clk);
    @(negedge i_clk);
    bid = o_quote.bid_price;
    ask = o_quote.ask_price;
endtask

task automatic test_reset();
    logic [31:0] bid;
    logic [31:0] ask;
    check_value("reset busy", 32'd0, 32'(o_book_is_busy));
    check_value("reset valid", 32'd0, 32'(o_data_valid));
    for (int s = 0; s < NUM_STOCKS; s++) begin
        read_quote(s, bid, ask);
        check_value("reset bid", 32'd0, bid);
        check_value("reset ask", 32'd0, ask);
    end
endtask

task automatic test_random_adds();
    logic [31:0] bid;
    logic [31:0] ask;
    for (int s = 0; s < 3; s++) begin
        for (int k = 0; k < 3; k++) begin
            add_random("random_adds", s, 1);
            add_random("random_adds", s, 0);
        end
    end
    for (int s = 0; s < NUM_STOCKS; s++) begin
        read_quote(s, bid, ask);
        check_value("isolation bid", best_price(s, 1), bid);
        check_value("isolation ask", best_price(s, 0), ask);
    end
    for (int k = 0; k < BOOK_DEPTH; k++) begin
        add_random("full_side", 3, 1);
    end
    // prices above the random range would become the best bid if taken
    for (int k = 0; k < 2; k++) begin
        send_cmd("full_side_ignored", order_pkg::OP_ADD, 1, 3, 16'd10, 32'd9000, next_id);
        next_id++;
    end
endtask

task automatic test_cancel();
    logic [31:0] prev;
    int          k;
    k = best_slot(0, 1);
    send_cmd("cancel_best", order_pkg::OP_CANCEL, 1, 0, 16'd0, 32'd0, m_id[0][1][k]);
    prev = best_price(0, 1);
    k = (best_slot(0, 1) == 0) ? 1 : 0;
    send_cmd("cancel_worse", order_pkg::OP_CANCEL, 1, 0, 16'd0, 32'd0, m_id[0][1][k]);
    check_value("cancel_worse unchanged", prev, last_bid);
    send_cmd("cancel_unknown", order_pkg::OP_CANCEL, 1, 0, 16'd0, 32'd0, 32'hDEAD0000);
    check_value("cancel_unknown unchanged", prev, last_bid);
    while (m_count[0][0] > 0) begin
        send_cmd("cancel_all", order_pkg::OP_CANCEL, 0, 0, 16'd0, 32'd0, m_id[0][0][0]);
    end
    check_value("cancel_all empty", 32'd0, last_ask);
endtask

task automatic test_execute();
    logic [31:0] prev;
    int          k;
    prev = best_price(1, 1);
    k = best_slot(1, 1);
    send_cmd("execute_partial", order_pkg::OP_EXECUTE, 1, 1, 16'd1, 32'd0, m_id[1][1][k]);
    check_value("execute_partial price", prev, last_bid);
    send_cmd("execute_full", order_pkg::OP_EXECUTE, 1, 1, m_qty[1][1][k], 32'd0,
             m_id[1][1][k]);
    k = best_slot(1, 0);
    send_cmd("execute_over", order_pkg::OP_EXECUTE, 0, 1, 16'hFFFF, 32'd0, m_id[1][0][k]);
endtask

task automatic test_backpressure();
    issue_cmd(order_pkg::OP_ADD, 1, 2, 16'd20, 32'd5000, next_id);
    model_apply(order_pkg::OP_ADD, 1, 2, 16'd20, 32'd5000, next_id);
    next_id++;
    wait_done("backpressure");
    // this add arrives while the result is unread
    issue_cmd(order_pkg::OP_ADD, 1, 2, 16'd20, 32'd6000, next_id);
    next_id++;
    for (int c = 0; c < 20; c++) begin
        @(negedge i_clk);
        check_value("backpressure valid", 32'd1, 32'(o_data_valid));
        check_value("backpressure busy", 32'd0, 32'(o_book_is_busy));
    end
    check_value("backpressure bid", 32'd5000, o_quote.bid_price);
    release_book();
    send_cmd("after_release", order_pkg::OP_ADD, 1, 2, 16'd20, 32'd7000, next_id);
    next_id++;
endtask

// ==== verification/order_book_tb.sv ====
`timescale 1ns/1ns
// directed testbench for order_book_top; stops at the first mismatch
// prices are kept nonzero because 0 stands for an empty side
module order_book_tb;

    localparam int NUM_STOCKS = 4;
    localparam int BOOK_DEPTH = 8;
    localparam int WAIT_LIMIT = 200;

    logic                  i_clk;
    logic                  i_reset_n;
    order_pkg::order_msg_t i_order;
    logic                  i_data_valid;
    logic                  i_trading_logic_ready;
    logic [1:0]            i_query_stock;
    logic                  o_book_is_busy;
    logic                  o_data_valid;
    book_pkg::quote_t      o_quote;
    logic [15:0]           lfsr_state;

    order_book_top #(
        .NUM_STOCKS (NUM_STOCKS),
        .BOOK_DEPTH (BOOK_DEPTH)
    ) dut0 (
        .i_clk                 (i_clk),
        .i_reset_n             (i_reset_n),
        .i_order               (i_order),
        .i_data_valid          (i_data_valid),
        .i_trading_logic_ready (i_trading_logic_ready),
        .i_query_stock         (i_query_stock),
        .o_book_is_busy        (o_book_is_busy),
        .o_data_valid          (o_data_valid),
        .o_quote               (o_quote)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] random_bits(input int nbits);
        logic [31:0] r;
        logic        lsb;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            lsb = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) begin
                lfsr_state = lfsr_state ^ 16'hB400;
            end
            r = {r[30:0], lsb};
        end
        return r;
    endfunction

    task automatic report_failure();
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected %0d, actual %0d", test_name, expected, actual);
            report_failure();
        end
    endtask

    `include "order_book_tests.svh"

    initial begin
        lfsr_state            = 16'd17171;
        i_reset_n             = 1'b0;
        i_order               = '0;
        i_data_valid          = 1'b0;
        i_trading_logic_ready = 1'b0;
        i_query_stock         = 2'd0;
        repeat (2) @(posedge i_clk);
        i_reset_n <= 1'b1;
        @(negedge i_clk);
        test_reset();
        test_random_adds();
        test_cancel();
        test_execute();
        test_backpressure();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== src/order_book_top.sv ====
`timescale 1ns/1ns
// limit order book, NUM_STOCKS up to 4 and BOOK_DEPTH at least 2
// a command is taken only while o_book_is_busy and o_data_valid are both low
module order_book_top #(
    parameter int NUM_STOCKS = 4,
    parameter int BOOK_DEPTH = 8
) (
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  order_pkg::order_msg_t i_order,
    input  logic                  i_data_valid,
    input  logic                  i_trading_logic_ready,
    input  logic [1:0]            i_query_stock,
    output logic                  o_book_is_busy,
    output logic                  o_data_valid,
    output book_pkg::quote_t      o_quote
);
    localparam int IDX_W = $clog2(BOOK_DEPTH);

    book_pkg::store_cmd_e bid_cmd;
    book_pkg::store_cmd_e ask_cmd;
    logic [1:0]           stock;
    logic [IDX_W-1:0]     index;
    order_pkg::entry_t    wr_entry;
    order_pkg::entry_t    bid_entry;
    order_pkg::entry_t    ask_entry;
    logic [IDX_W:0]       bid_count;
    logic [IDX_W:0]       ask_count;
    logic                 scan_start;
    logic                 scan_sample;
    logic                 scan_done;
    order_pkg::side_e     scan_side;
    order_pkg::price_t    scan_price;

    book_controller #(
        .NUM_STOCKS (NUM_STOCKS),
        .BOOK_DEPTH (BOOK_DEPTH)
    ) u_controller (
        .i_clk                 (i_clk),
        .i_reset_n             (i_reset_n),
        .i_order               (i_order),
        .i_data_valid          (i_data_valid),
        .i_trading_logic_ready (i_trading_logic_ready),
        .o_bid_cmd             (bid_cmd),
        .o_ask_cmd             (ask_cmd),
        .o_stock               (stock),
        .o_index               (index),
        .o_wr_entry            (wr_entry),
        .i_bid_entry           (bid_entry),
        .i_ask_entry           (ask_entry),
        .i_bid_count           (bid_count),
        .i_ask_count           (ask_count),
        .o_scan_start          (scan_start),
        .o_scan_sample         (scan_sample),
        .o_scan_done           (scan_done),
        .o_scan_side           (scan_side),
        .o_scan_price          (scan_price),
        .o_book_is_busy        (o_book_is_busy),
        .o_data_valid          (o_data_valid)
    );

    side_book #(
        .NUM_STOCKS (NUM_STOCKS),
        .BOOK_DEPTH (BOOK_DEPTH)
    ) u_bid_book (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_cmd     (bid_cmd),
        .i_stock   (stock),
        .i_index   (index),
        .i_entry   (wr_entry),
        .o_entry   (bid_entry),
        .o_count   (bid_count)
    );

    side_book #(
        .NUM_STOCKS (NUM_STOCKS),
        .BOOK_DEPTH (BOOK_DEPTH)
    ) u_ask_book (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_cmd     (ask_cmd),
        .i_stock   (stock),
        .i_index   (index),
        .i_entry   (wr_entry),
        .o_entry   (ask_entry),
        .o_count   (ask_count)
    );

    best_price_tracker #(
        .NUM_STOCKS (NUM_STOCKS)
    ) u_tracker (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_scan_start  (scan_start),
        .i_scan_sample (scan_sample),
        .i_scan_done   (scan_done),
        .i_side        (scan_side),
        .i_stock       (stock),
        .i_price       (scan_price),
        .i_query_stock (i_query_stock),
        .o_quote       (o_quote)
    );

endmodule

// ==== src/book_controller.sv ====
`timescale 1ns/1ns
// one command at a time; an add to a full side or an unknown id leaves the book as it was
// cancel and execute look only at the side named in the message
module book_controller #(
    parameter int NUM_STOCKS = 4,
    parameter int BOOK_DEPTH = 8,
    localparam int IDX_W = $clog2(BOOK_DEPTH)
) (
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  order_pkg::order_msg_t i_order,
    input  logic                  i_data_valid,
    input  logic                  i_trading_logic_ready,
    output book_pkg::store_cmd_e  o_bid_cmd,
    output book_pkg::store_cmd_e  o_ask_cmd,
    output logic [1:0]            o_stock,
    output logic [IDX_W-1:0]      o_index,
    output order_pkg::entry_t     o_wr_entry,
    input  order_pkg::entry_t     i_bid_entry,
    input  order_pkg::entry_t     i_ask_entry,
    input  logic [IDX_W:0]        i_bid_count,
    input  logic [IDX_W:0]        i_ask_count,
    output logic                  o_scan_start,
    output logic                  o_scan_sample,
    output logic                  o_scan_done,
    output order_pkg::side_e      o_scan_side,
    output order_pkg::price_t     o_scan_price,
    output logic                  o_book_is_busy,
    output logic                  o_data_valid
);
    localparam logic [IDX_W:0] DEPTH_C = (IDX_W + 1)'(BOOK_DEPTH);
    localparam logic [IDX_W:0] LAST_C  = (IDX_W + 1)'(BOOK_DEPTH - 1);

    book_pkg::ctrl_state_e state;
    order_pkg::order_msg_t msg_q;
    logic [IDX_W:0]        idx;
    order_pkg::entry_t     sel_entry;
    logic [IDX_W:0]        sel_count;
    logic                  is_bid;
    logic                  is_add;
    logic                  legal_cmd;
    logic                  id_match;
    logic                  full_fill;
    logic                  last_shift;
    book_pkg::store_cmd_e  cmd;

    assign is_bid     = (msg_q.side == order_pkg::SIDE_BID);
    assign is_add     = (msg_q.op == order_pkg::OP_ADD);
    assign sel_entry  = is_bid ? i_bid_entry : i_ask_entry;
    assign sel_count  = is_bid ? i_bid_count : i_ask_count;
    assign legal_cmd  = (i_order.op != 2'd3) && ({1'b0, i_order.stock} < 3'(NUM_STOCKS));
    assign id_match   = (sel_entry.order_id == msg_q.order_id);
    assign full_fill  = (msg_q.quantity >= sel_entry.quantity);
    // the step that moves the last occupied slot also lowers the count
    assign last_shift = ((idx + (IDX_W + 1)'(2)) >= sel_count);

    always_comb begin
        cmd        = book_pkg::SC_NONE;
        o_wr_entry = sel_entry;
        if (state == book_pkg::ST_APPLY) begin
            if (is_add) begin
                o_wr_entry = '{msg_q.quantity, msg_q.price, msg_q.order_id};
                if (sel_count < DEPTH_C) begin
                    cmd = book_pkg::SC_APPEND;
                end
            end else if (msg_q.op == order_pkg::OP_EXECUTE && !full_fill) begin
                o_wr_entry.quantity = sel_entry.quantity - msg_q.quantity;
                cmd = book_pkg::SC_SET_QTY;
            end
        end else if (state == book_pkg::ST_SHIFT) begin
            cmd = book_pkg::SC_SHIFT;
        end
    end

    // append goes at the current count, everything else at the walk index
    assign o_index   = (state == book_pkg::ST_APPLY && is_add) ? sel_count[IDX_W-1:0]
                                                               : idx[IDX_W-1:0];
    assign o_stock   = msg_q.stock;
    assign o_bid_cmd = is_bid ? cmd : book_pkg::SC_NONE;
    assign o_ask_cmd = is_bid ? book_pkg::SC_NONE : cmd;

    assign o_scan_start  = (state == book_pkg::ST_RESCAN) && (idx == '0);
    assign o_scan_sample = (state == book_pkg::ST_RESCAN) && (idx < sel_count);
    assign o_scan_done   = (state == book_pkg::ST_RESCAN) && (idx == LAST_C);
    assign o_scan_side   = msg_q.side;
    assign o_scan_price  = sel_entry.price;

    assign o_book_is_busy = (state != book_pkg::ST_IDLE) && (state != book_pkg::ST_FINISH);
    assign o_data_valid   = (state == book_pkg::ST_FINISH);

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state <= book_pkg::ST_IDLE;
            idx   <= '0;
        end else begin
            case (state)
                book_pkg::ST_IDLE: begin
                    idx <= '0;
                    if (i_data_valid && legal_cmd) begin
                        state <= (i_order.op == order_pkg::OP_ADD) ? book_pkg::ST_APPLY
                                                                   : book_pkg::ST_SEARCH;
                    end
                end
                book_pkg::ST_SEARCH: begin
                    if (idx >= sel_count) begin
                        state <= book_pkg::ST_FINISH;
                    end else if (id_match) begin
                        state <= book_pkg::ST_APPLY;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                book_pkg::ST_APPLY: begin
                    if (is_add || (msg_q.op == order_pkg::OP_EXECUTE && !full_fill)) begin
                        idx   <= '0;
                        state <= book_pkg::ST_RESCAN;
                    end else begin
                        state <= book_pkg::ST_SHIFT;
                    end
                end
                book_pkg::ST_SHIFT: begin
                    if (last_shift) begin
                        idx   <= '0;
                        state <= book_pkg::ST_RESCAN;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                book_pkg::ST_RESCAN: begin
                    if (idx == LAST_C) begin
                        state <= book_pkg::ST_FINISH;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                book_pkg::ST_FINISH: begin
                    if (i_trading_logic_ready) begin
                        state <= book_pkg::ST_IDLE;
                    end
                end
                default: state <= book_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == book_pkg::ST_IDLE && i_data_valid && legal_cmd) begin
            msg_q <= i_order;
        end
    end

endmodule

// ==== src/best_price_tracker.sv ====
`timescale 1ns/1ns
// best prices change only when a scan completes; 0 marks an empty side
module best_price_tracker #(
    parameter int NUM_STOCKS = 4
) (
    input  logic              i_clk,
    input  logic              i_reset_n,
    input  logic              i_scan_start,
    input  logic              i_scan_sample,
    input  logic              i_scan_done,
    input  order_pkg::side_e  i_side,
    input  logic [1:0]        i_stock,
    input  order_pkg::price_t i_price,
    input  logic [1:0]        i_query_stock,
    output book_pkg::quote_t  o_quote
);
    order_pkg::price_t running;
    order_pkg::price_t base;
    order_pkg::price_t merged;
    order_pkg::price_t best_bid [NUM_STOCKS];
    order_pkg::price_t best_ask [NUM_STOCKS];
    logic              better;

    // start restarts from empty in the same cycle as the first sample
    assign base   = i_scan_start ? '0 : running;
    assign better = (i_side == order_pkg::SIDE_BID) ? (i_price > base) : (i_price < base);
    assign merged = (i_scan_sample && (base == '0 || better)) ? i_price : base;

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            running <= '0;
            o_quote <= '0;
            for (int s = 0; s < NUM_STOCKS; s++) begin
                best_bid[s] <= '0;
                best_ask[s] <= '0;
            end
        end else begin
            running <= merged;
            // done arrives with the last slot, so merged already holds it
            if (i_scan_done) begin
                if (i_side == order_pkg::SIDE_BID) begin
                    best_bid[i_stock] <= merged;
                end else begin
                    best_ask[i_stock] <= merged;
                end
            end
            o_quote.bid_price <= best_bid[i_query_stock];
            o_quote.ask_price <= best_ask[i_query_stock];
        end
    end

endmodule

// ==== src/side_book.sv ====
`timescale 1ns/1ns
// one side of the book; entries stay packed from slot 0 upwards
// the caller never appends to a full stock or shifts an empty one
module side_book #(
    parameter int NUM_STOCKS = 4,
    parameter int BOOK_DEPTH = 8,
    localparam int IDX_W = $clog2(BOOK_DEPTH)
) (
    input  logic                 i_clk,
    input  logic                 i_reset_n,
    input  book_pkg::store_cmd_e i_cmd,
    input  logic [1:0]           i_stock,
    input  logic [IDX_W-1:0]     i_index,
    input  order_pkg::entry_t    i_entry,
    output order_pkg::entry_t    o_entry,
    output logic [IDX_W:0]       o_count
);
    localparam logic [IDX_W:0] DEPTH_C = (IDX_W + 1)'(BOOK_DEPTH);

    order_pkg::entry_t mem [NUM_STOCKS][BOOK_DEPTH];
    logic [IDX_W:0]    count [NUM_STOCKS];
    logic [IDX_W:0]    next_idx;
    logic [IDX_W:0]    last_slot;
    logic              at_top;

    assign next_idx  = {1'b0, i_index} + 1'b1;
    assign last_slot = count[i_stock] - 1'b1;
    // index is count-2 or above
    assign at_top    = (next_idx + 1'b1) >= count[i_stock];
    assign o_entry   = mem[i_stock][i_index];
    assign o_count   = count[i_stock];

    always_ff @(posedge i_clk) begin
        case (i_cmd)
            book_pkg::SC_APPEND, book_pkg::SC_SET_QTY: begin
                mem[i_stock][i_index] <= i_entry;
            end
            book_pkg::SC_SHIFT: begin
                if (next_idx < DEPTH_C) begin
                    mem[i_stock][i_index] <= mem[i_stock][next_idx[IDX_W-1:0]];
                end
                // clear after the copy so removing the last slot leaves zeros
                if (at_top) begin
                    mem[i_stock][last_slot[IDX_W-1:0]] <= '0;
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            for (int s = 0; s < NUM_STOCKS; s++) begin
                count[s] <= '0;
            end
        end else if (i_cmd == book_pkg::SC_APPEND) begin
            count[i_stock] <= count[i_stock] + 1'b1;
        end else if (i_cmd == book_pkg::SC_SHIFT && at_top) begin
            count[i_stock] <= count[i_stock] - 1'b1;
        end
    end

endmodule

// ==== src/book_pkg.sv ====
// types used between the book blocks; needs order_pkg compiled first
package book_pkg;

    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_SEARCH = 3'd1,
        ST_APPLY  = 3'd2,
        ST_SHIFT  = 3'd3,
        ST_RESCAN = 3'd4,
        ST_FINISH = 3'd5
    } ctrl_state_e;

    // command to one side store
    typedef enum logic [1:0] {
        SC_NONE    = 2'd0,
        SC_APPEND  = 2'd1,
        SC_SET_QTY = 2'd2,
        SC_SHIFT   = 2'd3
    } store_cmd_e;

    // best prices of one stock, 0 when that side is empty
    typedef struct packed {
        order_pkg::price_t bid_price;
        order_pkg::price_t ask_price;
    } quote_t;

endpackage

// ==== src/order_pkg.sv ====
// market message types; the stock field is 2 bits, so at most 4 instruments
// a price of 0 means no price on an empty side
package order_pkg;

    typedef logic [31:0] price_t;
    typedef logic [15:0] qty_t;
    typedef logic [31:0] order_id_t;

    typedef enum logic {
        SIDE_ASK = 1'b0,
        SIDE_BID = 1'b1
    } side_e;

    // code 3 is not a command
    typedef enum logic [1:0] {
        OP_ADD     = 2'd0,
        OP_CANCEL  = 2'd1,
        OP_EXECUTE = 2'd2
    } op_e;

    typedef struct packed {
        side_e      side;
        op_e        op;
        logic [1:0] stock;
        qty_t       quantity;
        price_t     price;
        order_id_t  order_id;
    } order_msg_t;

    typedef struct packed {
        qty_t      quantity;
        price_t    price;
        order_id_t order_id;
    } entry_t;

endpackage
